//--- build.f
hdl/mips_pkg.sv
hdl/regfile.sv
hdl/instr_decoder.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/id_stage.sv
testbench/id_stage_tb.sv

//--- hdl/branch_unit.sv
module branch_unit (
    input  mips_pkg::word_t    pc,
    input  mips_pkg::instr_u   inst,
    input  mips_pkg::br_kind_t br_kind,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    output logic               br_taken,
    output mips_pkg::word_t    br_addr
);

    mips_pkg::word_t pc_plus_4;
    mips_pkg::word_t rel_target; // conditional branches
    mips_pkg::word_t abs_target; // j / jal
    mips_pkg::word_t target;
    logic            rs_eq_rt;
    logic            rs_neg;
    logic            rs_zero;

    assign pc_plus_4 = pc + 32'd4;

    assign rel_target = pc_plus_4 + {{14{inst.i_fmt.imm[15]}}, inst.i_fmt.imm, 2'b00};
    assign abs_target = {pc_plus_4[31:28], inst[25:0], 2'b00};

    assign rs_eq_rt = (rs_data == rt_data);
    assign rs_neg   = rs_data[31];
    assign rs_zero  = (rs_data == '0);

    always_comb begin
        br_taken = 1'b0;
        target   = rel_target;
        unique case (br_kind)
            mips_pkg::br_beq:  br_taken = rs_eq_rt;
            mips_pkg::br_bne:  br_taken = !rs_eq_rt;
            mips_pkg::br_bgez: br_taken = !rs_neg;
            mips_pkg::br_bgtz: br_taken = !rs_neg && !rs_zero;
            mips_pkg::br_blez: br_taken = rs_neg || rs_zero;
            mips_pkg::br_bltz: br_taken = rs_neg;
            mips_pkg::br_j: begin
                br_taken = 1'b1;
                target   = abs_target;
            end
            mips_pkg::br_jr: begin
                br_taken = 1'b1;
                target   = rs_data; // register jump takes the forwarded rs
            end
            default: br_taken = 1'b0;
        endcase
    end

    assign br_addr = br_taken ? target : '0;

endmodule

//--- hdl/id_stage.sv
module id_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  mips_pkg::word_t               if_pc,
    input  logic                          if_valid,
    input  mips_pkg::word_t               inst,
    input  logic                          wb_we,
    input  mips_pkg::reg_addr_t           wb_waddr,
    input  mips_pkg::word_t               wb_wdata,
    input  logic                          ex_fwd_we,
    input  mips_pkg::reg_addr_t           ex_fwd_addr,
    input  mips_pkg::word_t               ex_fwd_data,
    input  logic                          mem_fwd_we,
    input  mips_pkg::reg_addr_t           mem_fwd_addr,
    input  mips_pkg::word_t               mem_fwd_data,
    input  logic                          wb_fwd_we,
    input  mips_pkg::reg_addr_t           wb_fwd_addr,
    input  mips_pkg::word_t               wb_fwd_data,
    output mips_pkg::word_t               id_pc,
    output mips_pkg::word_t               id_inst,
    output logic [mips_pkg::alu_op_w-1:0] alu_op,
    output logic [mips_pkg::src1_w-1:0]   alu_src1,
    output logic [mips_pkg::src2_w-1:0]   alu_src2,
    output logic                          data_ram_en,
    output logic [3:0]                    data_ram_wen,
    output logic                          rf_we,
    output mips_pkg::reg_addr_t           rf_waddr,
    output logic                          sel_rf_res,
    output mips_pkg::word_t               rs_data,
    output mips_pkg::word_t               rt_data,
    output logic                          br_taken,
    output mips_pkg::word_t               br_addr
);

    logic               id_valid;
    mips_pkg::instr_u   inst_u;
    mips_pkg::word_t    rf_rs_data;
    mips_pkg::word_t    rf_rt_data;
    logic               dec_rf_we;
    logic               dec_ram_en;
    logic [3:0]         dec_ram_wen;
    mips_pkg::br_kind_t br_kind;
    logic               br_link;
    logic               bu_taken;

    // if/id register, frozen while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            id_pc    <= '0;
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_pc    <= if_pc;
            id_valid <= if_valid;
        end
    end

    assign inst_u  = inst; // sram data already lines up with id_pc
    assign id_inst = inst;

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (inst_u.r_fmt.rs),
        .raddr2 (inst_u.r_fmt.rt),
        .rdata1 (rf_rs_data),
        .rdata2 (rf_rt_data),
        .we     (wb_we),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata)
    );

    instr_decoder instr_decoder_inst (
        .inst         (inst_u),
        .alu_op       (alu_op),
        .alu_src1     (alu_src1),
        .alu_src2     (alu_src2),
        .data_ram_en  (dec_ram_en),
        .data_ram_wen (dec_ram_wen),
        .rf_we        (dec_rf_we),
        .rf_waddr     (rf_waddr),
        .sel_rf_res   (sel_rf_res),
        .br_kind      (br_kind),
        .br_link      (br_link)
    );

    operand_forward operand_forward_inst (
        .rs           (inst_u.r_fmt.rs),
        .rt           (inst_u.r_fmt.rt),
        .rf_rs_data   (rf_rs_data),
        .rf_rt_data   (rf_rt_data),
        .ex_fwd_we    (ex_fwd_we),
        .ex_fwd_addr  (ex_fwd_addr),
        .ex_fwd_data  (ex_fwd_data),
        .mem_fwd_we   (mem_fwd_we),
        .mem_fwd_addr (mem_fwd_addr),
        .mem_fwd_data (mem_fwd_data),
        .wb_fwd_we    (wb_fwd_we),
        .wb_fwd_addr  (wb_fwd_addr),
        .wb_fwd_data  (wb_fwd_data),
        .rs_data      (rs_data),
        .rt_data      (rt_data)
    );

    branch_unit branch_unit_inst (
        .pc       (id_pc),
        .inst     (inst_u),
        .br_kind  (br_kind),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .br_taken (bu_taken),
        .br_addr  (br_addr)
    );

    // no side effects from an empty slot
    assign rf_we        = id_valid & (dec_rf_we | br_link);
    assign data_ram_en  = id_valid & dec_ram_en;
    assign data_ram_wen = {4{id_valid}} & dec_ram_wen;
    assign br_taken     = id_valid & bu_taken;

endmodule

//--- hdl/instr_decoder.sv
module instr_decoder (
    input  mips_pkg::instr_u              inst,
    output logic [mips_pkg::alu_op_w-1:0] alu_op,
    output logic [mips_pkg::src1_w-1:0]   alu_src1,
    output logic [mips_pkg::src2_w-1:0]   alu_src2,
    output logic                          data_ram_en,
    output logic [3:0]                    data_ram_wen,
    output logic                          rf_we,
    output mips_pkg::reg_addr_t           rf_waddr,
    output logic                          sel_rf_res,
    output mips_pkg::br_kind_t            br_kind,
    output logic                          br_link
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       special;
    logic       regimm;

    logic inst_add, inst_addu, inst_sub, inst_subu, inst_and, inst_or, inst_xor, inst_nor;
    logic inst_slt, inst_sltu, inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_jr, inst_jalr, inst_j, inst_jal, inst_beq, inst_bne, inst_blez, inst_bgtz;
    logic inst_bltz, inst_bgez, inst_bltzal, inst_bgezal;
    logic inst_addi, inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori;
    logic inst_lui, inst_lw, inst_sw;

    logic r_alu;   // three-register alu ops, rd destination
    logic r_shamt; // shift by the shamt field
    logic i_simm;  // sign-extended immediate ops
    logic i_zimm;  // zero-extended logical immediates

    assign opcode  = inst.r_fmt.opcode;
    assign funct   = inst.r_fmt.funct;
    assign special = (opcode == mips_pkg::op_special);
    assign regimm  = (opcode == mips_pkg::op_regimm);

    assign inst_add    = special && funct == mips_pkg::fn_add;
    assign inst_addu   = special && funct == mips_pkg::fn_addu;
    assign inst_sub    = special && funct == mips_pkg::fn_sub;
    assign inst_subu   = special && funct == mips_pkg::fn_subu;
    assign inst_and    = special && funct == mips_pkg::fn_and;
    assign inst_or     = special && funct == mips_pkg::fn_or;
    assign inst_xor    = special && funct == mips_pkg::fn_xor;
    assign inst_nor    = special && funct == mips_pkg::fn_nor;
    assign inst_slt    = special && funct == mips_pkg::fn_slt;
    assign inst_sltu   = special && funct == mips_pkg::fn_sltu;
    assign inst_sll    = special && funct == mips_pkg::fn_sll;
    assign inst_srl    = special && funct == mips_pkg::fn_srl;
    assign inst_sra    = special && funct == mips_pkg::fn_sra;
    assign inst_sllv   = special && funct == mips_pkg::fn_sllv;
    assign inst_srlv   = special && funct == mips_pkg::fn_srlv;
    assign inst_srav   = special && funct == mips_pkg::fn_srav;
    assign inst_jr     = special && funct == mips_pkg::fn_jr;
    assign inst_jalr   = special && funct == mips_pkg::fn_jalr;
    assign inst_bltz   = regimm && inst.i_fmt.rt == mips_pkg::rt_bltz;
    assign inst_bgez   = regimm && inst.i_fmt.rt == mips_pkg::rt_bgez;
    assign inst_bltzal = regimm && inst.i_fmt.rt == mips_pkg::rt_bltzal;
    assign inst_bgezal = regimm && inst.i_fmt.rt == mips_pkg::rt_bgezal;
    assign inst_j      = (opcode == mips_pkg::op_j);
    assign inst_jal    = (opcode == mips_pkg::op_jal);
    assign inst_beq    = (opcode == mips_pkg::op_beq);
    assign inst_bne    = (opcode == mips_pkg::op_bne);
    assign inst_blez   = (opcode == mips_pkg::op_blez);
    assign inst_bgtz   = (opcode == mips_pkg::op_bgtz);
    assign inst_addi   = (opcode == mips_pkg::op_addi);
    assign inst_addiu  = (opcode == mips_pkg::op_addiu);
    assign inst_slti   = (opcode == mips_pkg::op_slti);
    assign inst_sltiu  = (opcode == mips_pkg::op_sltiu);
    assign inst_andi   = (opcode == mips_pkg::op_andi);
    assign inst_ori    = (opcode == mips_pkg::op_ori);
    assign inst_xori   = (opcode == mips_pkg::op_xori);
    assign inst_lui    = (opcode == mips_pkg::op_lui);
    assign inst_lw     = (opcode == mips_pkg::op_lw);
    assign inst_sw     = (opcode == mips_pkg::op_sw);

    assign r_alu = inst_add | inst_addu | inst_sub | inst_subu | inst_and | inst_or
                 | inst_xor | inst_nor | inst_slt | inst_sltu | inst_sllv | inst_srlv
                 | inst_srav;
    assign r_shamt = inst_sll | inst_srl | inst_sra;
    assign i_simm  = inst_addi | inst_addiu | inst_slti | inst_sltiu;
    assign i_zimm  = inst_andi | inst_ori | inst_xori;

    // link instructions compute pc + 8 in the alu
    assign br_link = inst_jal | inst_jalr | inst_bltzal | inst_bgezal;

    always_comb begin
        alu_src1 = '0;
        alu_src1[mips_pkg::src1_rs] = r_alu | i_simm | i_zimm | inst_lw | inst_sw;
        alu_src1[mips_pkg::src1_pc] = br_link;
        alu_src1[mips_pkg::src1_sa] = r_shamt;

        alu_src2 = '0;
        alu_src2[mips_pkg::src2_rt]    = r_alu | r_shamt;
        alu_src2[mips_pkg::src2_simm]  = i_simm | inst_lui | inst_lw | inst_sw;
        alu_src2[mips_pkg::src2_eight] = br_link;
        alu_src2[mips_pkg::src2_zimm]  = i_zimm;
    end

    always_comb begin
        alu_op = '0;
        alu_op[mips_pkg::alu_add]  = inst_add | inst_addu | inst_addi | inst_addiu
                                   | inst_lw | inst_sw | br_link; // address and link math
        alu_op[mips_pkg::alu_sub]  = inst_sub | inst_subu;
        alu_op[mips_pkg::alu_slt]  = inst_slt | inst_slti;
        alu_op[mips_pkg::alu_sltu] = inst_sltu | inst_sltiu;
        alu_op[mips_pkg::alu_and]  = inst_and | inst_andi;
        alu_op[mips_pkg::alu_nor]  = inst_nor;
        alu_op[mips_pkg::alu_or]   = inst_or | inst_ori;
        alu_op[mips_pkg::alu_xor]  = inst_xor | inst_xori;
        alu_op[mips_pkg::alu_sll]  = inst_sll | inst_sllv;
        alu_op[mips_pkg::alu_srl]  = inst_srl | inst_srlv;
        alu_op[mips_pkg::alu_sra]  = inst_sra | inst_srav;
        alu_op[mips_pkg::alu_lui]  = inst_lui;
    end

    assign data_ram_en  = inst_lw | inst_sw;
    assign data_ram_wen = inst_sw ? 4'b1111 : 4'b0000;
    assign sel_rf_res   = inst_lw;

    // link writes are reported through br_link
    assign rf_we = r_alu | r_shamt | i_simm | i_zimm | inst_lui | inst_lw;

    always_comb begin
        if (r_alu || r_shamt || inst_jalr)
            rf_waddr = inst.r_fmt.rd;
        else if (i_simm || i_zimm || inst_lui || inst_lw)
            rf_waddr = inst.i_fmt.rt;
        else if (inst_jal || inst_bltzal || inst_bgezal)
            rf_waddr = mips_pkg::ra_reg;
        else
            rf_waddr = '0;
    end

    always_comb begin
        if (inst_beq)
            br_kind = mips_pkg::br_beq;
        else if (inst_bne)
            br_kind = mips_pkg::br_bne;
        else if (inst_bgez || inst_bgezal)
            br_kind = mips_pkg::br_bgez;
        else if (inst_bgtz)
            br_kind = mips_pkg::br_bgtz;
        else if (inst_blez)
            br_kind = mips_pkg::br_blez;
        else if (inst_bltz || inst_bltzal)
            br_kind = mips_pkg::br_bltz;
        else if (inst_j || inst_jal)
            br_kind = mips_pkg::br_j;
        else if (inst_jr || inst_jalr)
            br_kind = mips_pkg::br_jr;
        else
            br_kind = mips_pkg::br_none;
    end

endmodule

//--- hdl/mips_pkg.sv
package mips_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [data_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    localparam reg_addr_t ra_reg = 5'd31; // link register

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    // same word seen as R-type or I-type, jump index is bits 25:0
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    // opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_regimm  = 6'b000001;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_blez    = 6'b000110;
    localparam logic [5:0] op_bgtz    = 6'b000111;
    localparam logic [5:0] op_addi    = 6'b001000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_slti    = 6'b001010;
    localparam logic [5:0] op_sltiu   = 6'b001011;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;

    // function codes under op_special
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_sra  = 6'b000011;
    localparam logic [5:0] fn_sllv = 6'b000100;
    localparam logic [5:0] fn_srlv = 6'b000110;
    localparam logic [5:0] fn_srav = 6'b000111;
    localparam logic [5:0] fn_jr   = 6'b001000;
    localparam logic [5:0] fn_jalr = 6'b001001;
    localparam logic [5:0] fn_add  = 6'b100000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_sub  = 6'b100010;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_slt  = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    // rt field under op_regimm
    localparam reg_addr_t rt_bltz   = 5'b00000;
    localparam reg_addr_t rt_bgez   = 5'b00001;
    localparam reg_addr_t rt_bltzal = 5'b10000;
    localparam reg_addr_t rt_bgezal = 5'b10001;

    // one-hot alu operation, add is the msb
    localparam int alu_op_w = 12;
    localparam int alu_add  = 11;
    localparam int alu_sub  = 10;
    localparam int alu_slt  = 9;
    localparam int alu_sltu = 8;
    localparam int alu_and  = 7;
    localparam int alu_nor  = 6;
    localparam int alu_or   = 5;
    localparam int alu_xor  = 4;
    localparam int alu_sll  = 3;
    localparam int alu_srl  = 2;
    localparam int alu_sra  = 1;
    localparam int alu_lui  = 0;

    // operand selects, one-hot
    localparam int src1_w     = 3;
    localparam int src1_rs    = 0;
    localparam int src1_pc    = 1;
    localparam int src1_sa    = 2;
    localparam int src2_w     = 4;
    localparam int src2_rt    = 0;
    localparam int src2_simm  = 1;
    localparam int src2_eight = 2; // return address is pc + 8
    localparam int src2_zimm  = 3;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_bgez,
        br_bgtz,
        br_blez,
        br_bltz,
        br_j,
        br_jr
    } br_kind_t;

endpackage

//--- hdl/operand_forward.sv
module operand_forward (
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  mips_pkg::word_t     rf_rs_data,
    input  mips_pkg::word_t     rf_rt_data,
    input  logic                ex_fwd_we,
    input  mips_pkg::reg_addr_t ex_fwd_addr,
    input  mips_pkg::word_t     ex_fwd_data,
    input  logic                mem_fwd_we,
    input  mips_pkg::reg_addr_t mem_fwd_addr,
    input  mips_pkg::word_t     mem_fwd_data,
    input  logic                wb_fwd_we,
    input  mips_pkg::reg_addr_t wb_fwd_addr,
    input  mips_pkg::word_t     wb_fwd_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data
);

    // youngest producer wins, $0 always comes from the regfile
    function automatic mips_pkg::word_t pick(input mips_pkg::reg_addr_t src,
                                             input mips_pkg::word_t     rf_data,
                                             input logic                ex_we,
                                             input mips_pkg::reg_addr_t ex_addr,
                                             input mips_pkg::word_t     ex_data,
                                             input logic                mem_we,
                                             input mips_pkg::reg_addr_t mem_addr,
                                             input mips_pkg::word_t     mem_data,
                                             input logic                wb_we,
                                             input mips_pkg::reg_addr_t wb_addr,
                                             input mips_pkg::word_t     wb_data);
        if (src == '0)
            return rf_data;
        else if (ex_we && ex_addr == src)
            return ex_data;
        else if (mem_we && mem_addr == src)
            return mem_data;
        else if (wb_we && wb_addr == src)
            return wb_data;
        else
            return rf_data;
    endfunction

    assign rs_data = pick(rs, rf_rs_data, ex_fwd_we, ex_fwd_addr, ex_fwd_data,
                          mem_fwd_we, mem_fwd_addr, mem_fwd_data,
                          wb_fwd_we, wb_fwd_addr, wb_fwd_data);
    assign rt_data = pick(rt, rf_rt_data, ex_fwd_we, ex_fwd_addr, ex_fwd_data,
                          mem_fwd_we, mem_fwd_addr, mem_fwd_data,
                          wb_fwd_we, wb_fwd_addr, wb_fwd_data);

endmodule

//--- hdl/regfile.sv
module regfile (
    input  logic                clk,
    input  mips_pkg::reg_addr_t raddr1,
    input  mips_pkg::reg_addr_t raddr2,
    output mips_pkg::word_t     rdata1,
    output mips_pkg::word_t     rdata2,
    input  logic                we,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata
);

    mips_pkg::word_t regs [1:31]; // $0 has no storage

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // no write bypass, forwarding covers the wb stage
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- testbench/id_stage_tb.sv
module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int capture_timeout = 8; // cycles

    logic        clk;
    logic        rst;
    logic        stall;
    logic [31:0] if_pc;
    logic        if_valid;
    logic [31:0] inst;
    logic        wb_we;
    logic [4:0]  wb_waddr;
    logic [31:0] wb_wdata;
    logic        ex_fwd_we;
    logic [4:0]  ex_fwd_addr;
    logic [31:0] ex_fwd_data;
    logic        mem_fwd_we;
    logic [4:0]  mem_fwd_addr;
    logic [31:0] mem_fwd_data;
    logic        wb_fwd_we;
    logic [4:0]  wb_fwd_addr;
    logic [31:0] wb_fwd_data;
    logic [31:0] id_pc;
    logic [31:0] id_inst;
    logic [11:0] alu_op;
    logic [2:0]  alu_src1;
    logic [3:0]  alu_src2;
    logic        data_ram_en;
    logic [3:0]  data_ram_wen;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic        sel_rf_res;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        br_taken;
    logic [31:0] br_addr;

    logic [31:0] v [0:16];  // fields of the current decode line
    logic [31:0] fv [0:8];  // ex, mem, wb triples for the next decode line
    logic        fwd_pending;
    int unsigned seed;
    int          line_no;
    int          n_dec;

    id_stage id_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic end_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic fail_with_reason(input string reason);
        $display("ERROR %0t: %s", $time, reason);
        end_with_failure();
    endtask

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %0t: line %0d, %s is %h, expected %h",
                     $time, line_no, what, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic write_register(input logic [31:0] addr, input logic [31:0] data);
        wb_we    = 1'b1;
        wb_waddr = addr[4:0];
        wb_wdata = data;
        @(posedge clk);
        #1;
        wb_we = 1'b0; // visible on the read path from here on
    endtask

    task automatic drive_forwarding();
        if (fwd_pending) begin
            ex_fwd_we    = fv[0][0];
            ex_fwd_addr  = fv[1][4:0];
            ex_fwd_data  = fv[2];
            mem_fwd_we   = fv[3][0];
            mem_fwd_addr = fv[4][4:0];
            mem_fwd_data = fv[5];
            wb_fwd_we    = fv[6][0];
            wb_fwd_addr  = fv[7][4:0];
            wb_fwd_data  = fv[8];
            fwd_pending  = 1'b0;
        end else begin
            // enables off, the rest is noise
            ex_fwd_we    = 1'b0;
            ex_fwd_addr  = 5'($urandom);
            ex_fwd_data  = $urandom;
            mem_fwd_we   = 1'b0;
            mem_fwd_addr = 5'($urandom);
            mem_fwd_data = $urandom;
            wb_fwd_we    = 1'b0;
            wb_fwd_addr  = 5'($urandom);
            wb_fwd_data  = $urandom;
        end
    endtask

    // v: valid stall pc inst, then the expected outputs in file order
    task automatic run_decode();
        int cycles;
        if_valid = v[0][0];
        stall    = v[1][0];
        if_pc    = v[2];
        inst     = v[3];
        drive_forwarding();
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!v[1][0] && id_pc !== v[2] && cycles < capture_timeout);
        if (!v[1][0] && id_pc !== v[2])
            fail_with_reason($sformatf("line %0d: IF/ID never captured the new pc", line_no));
        check("capture latency", cycles, 32'd1);
        check("id_pc", id_pc, v[4]);
        check("id_inst", id_inst, v[3]);
        check("alu_op", alu_op, v[5]);
        check("alu_src1", alu_src1, v[6]);
        check("alu_src2", alu_src2, v[7]);
        check("data_ram_en", data_ram_en, v[8]);
        check("data_ram_wen", data_ram_wen, v[9]);
        check("rf_we", rf_we, v[10]);
        check("rf_waddr", rf_waddr, v[11]);
        check("sel_rf_res", sel_rf_res, v[12]);
        check("rs_data", rs_data, v[13]);
        check("rt_data", rt_data, v[14]);
        check("br_taken", br_taken, v[15]);
        check("br_addr", br_addr, v[16]);
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] wa;
        logic [31:0] wd;
        rst         = 1'b1;
        stall       = 1'b0;
        if_pc       = '0;
        if_valid    = 1'b0;
        inst        = '0;
        wb_we       = 1'b0;
        wb_waddr    = '0;
        wb_wdata    = '0;
        fwd_pending = 1'b0;
        line_no     = 0;
        n_dec       = 0;
        seed        = 32'h852d_4955;
        void'($urandom(seed));
        drive_forwarding();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("testbench/id_stage_tests.txt", "r");
        if (fd == 0)
            fail_with_reason("cannot open testbench/id_stage_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n == 0 || line.len() < 2 || line[0] == "#")
                continue;
            case (line[0])
                "w": begin
                    n = $sscanf(line, "w %h %h", wa, wd);
                    if (n != 2)
                        fail_with_reason($sformatf("bad write on line %0d", line_no));
                    else
                        write_register(wa, wd);
                end
                "f": begin
                    n = $sscanf(line, "f %h %h %h %h %h %h %h %h %h", fv[0], fv[1], fv[2],
                                fv[3], fv[4], fv[5], fv[6], fv[7], fv[8]);
                    if (n != 9)
                        fail_with_reason($sformatf("bad forwarding on line %0d", line_no));
                    else
                        fwd_pending = 1'b1;
                end
                "d": begin
                    n = $sscanf(line, "d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                                v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
                    if (n != 17) begin
                        fail_with_reason($sformatf("bad decode vector on line %0d", line_no));
                    end else begin
                        run_decode();
                        n_dec++;
                    end
                end
                default: fail_with_reason($sformatf("unknown line kind on line %0d", line_no));
            endcase
        end
        $fclose(fd);

        if (n_dec == 0) begin
            fail_with_reason("the test file holds no decode vectors");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- testbench/id_stage_tests.txt
# w reg data | f ex_we ex_a ex_d mem_we mem_a mem_d wb_we wb_a wb_d (next d line only)
# d valid stall pc inst | id_pc alu_op src1 src2 ram_en wen rf_we waddr sel rs rt taken addr
w 01 00000005
w 02 00000007
w 03 fffffff0
w 04 00000000
w 05 00001000
w 07 00000077
w 08 00000010
w 09 00000099
w 0b 000000bb
w 0f 000000ff
w 11 00000111
w 00 deadbeef
d 0 0 00000000 aca20004 00000000 800 1 2 0 0 0 00 0 00001000 00000007 0 00000000
d 0 0 00000000 0c000100 00000000 800 2 4 0 0 0 1f 0 00000000 00000000 0 00000400
d 1 0 00000100 00221820 00000100 800 1 1 0 0 1 03 0 00000005 00000007 0 00000000
d 1 0 00000104 00413023 00000104 400 1 1 0 0 1 06 0 00000007 00000005 0 00000000
d 1 0 00000108 342700f0 00000108 020 1 8 0 0 1 07 0 00000005 00000077 0 00000000
d 1 0 0000010c 3c091234 0000010c 001 0 2 0 0 1 09 0 00000000 00000099 0 00000000
d 1 0 00000110 0061502a 00000110 200 1 1 0 0 1 0a 0 fffffff0 00000005 0 00000000
d 1 0 00000114 2c4bffff 00000114 100 1 2 0 0 1 0b 0 00000007 000000bb 0 00000000
d 1 0 00000118 00026100 00000118 008 4 1 0 0 1 0c 0 00000000 00000007 0 00000000
d 1 0 0000011c 00236807 0000011c 002 1 1 0 0 1 0d 0 00000005 fffffff0 0 00000000
d 1 0 00000120 00227027 00000120 040 1 1 0 0 1 0e 0 00000005 00000007 0 00000000
d 1 0 00000124 8caf0008 00000124 800 1 2 1 0 1 0f 1 00001000 000000ff 0 00000000
d 1 0 00000128 aca20004 00000128 800 1 2 1 f 0 00 0 00001000 00000007 0 00000000
d 1 0 0000012c 00011820 0000012c 800 1 1 0 0 1 03 0 00000000 00000005 0 00000000
f 1 08 aaaa0001 1 08 bbbb0002 1 08 cccc0003
d 1 0 00000130 01081820 00000130 800 1 1 0 0 1 03 0 aaaa0001 aaaa0001 0 00000000
f 0 08 aaaa0001 1 08 bbbb0002 0 08 cccc0003
d 1 0 00000134 01081820 00000134 800 1 1 0 0 1 03 0 bbbb0002 bbbb0002 0 00000000
f 0 08 aaaa0001 0 08 bbbb0002 1 08 cccc0003
d 1 0 00000138 01081820 00000138 800 1 1 0 0 1 03 0 cccc0003 cccc0003 0 00000000
d 1 0 0000013c 01081820 0000013c 800 1 1 0 0 1 03 0 00000010 00000010 0 00000000
f 1 00 aaaa0001 1 00 bbbb0002 1 00 cccc0003
d 1 0 00000140 00001820 00000140 800 1 1 0 0 1 03 0 00000000 00000000 0 00000000
d 1 0 00000200 10210004 00000200 000 0 0 0 0 0 00 0 00000005 00000005 1 00000214
d 1 0 00000204 10220004 00000204 000 0 0 0 0 0 00 0 00000005 00000007 0 00000000
d 1 0 00000300 1422fffe 00000300 000 0 0 0 0 0 00 0 00000005 00000007 1 000002fc
d 1 0 00000304 1421fffe 00000304 000 0 0 0 0 0 00 0 00000005 00000005 0 00000000
d 1 0 00000400 04210010 00000400 000 0 0 0 0 0 00 0 00000005 00000005 1 00000444
d 1 0 00000400 04810010 00000400 000 0 0 0 0 0 00 0 00000000 00000005 1 00000444
d 1 0 00000400 04610010 00000400 000 0 0 0 0 0 00 0 fffffff0 00000005 0 00000000
d 1 0 00000400 1c200010 00000400 000 0 0 0 0 0 00 0 00000005 00000000 1 00000444
d 1 0 00000400 1c800010 00000400 000 0 0 0 0 0 00 0 00000000 00000000 0 00000000
d 1 0 00000400 1c600010 00000400 000 0 0 0 0 0 00 0 fffffff0 00000000 0 00000000
d 1 0 00000400 18200010 00000400 000 0 0 0 0 0 00 0 00000005 00000000 0 00000000
d 1 0 00000400 18800010 00000400 000 0 0 0 0 0 00 0 00000000 00000000 1 00000444
d 1 0 00000400 18600010 00000400 000 0 0 0 0 0 00 0 fffffff0 00000000 1 00000444
d 1 0 00000400 04200010 00000400 000 0 0 0 0 0 00 0 00000005 00000000 0 00000000
d 1 0 00000400 04800010 00000400 000 0 0 0 0 0 00 0 00000000 00000000 0 00000000
d 1 0 00000400 04600010 00000400 000 0 0 0 0 0 00 0 fffffff0 00000000 1 00000444
d 1 0 00000400 04310010 00000400 800 2 4 0 0 1 1f 0 00000005 00000111 1 00000444
d 1 0 10000500 08000100 10000500 000 0 0 0 0 0 00 0 00000000 00000000 1 10000400
d 1 0 10000500 0c000100 10000500 800 2 4 0 0 1 1f 0 00000000 00000000 1 10000400
d 1 0 00000600 00a00008 00000600 000 0 0 0 0 0 00 0 00001000 00000000 1 00001000
d 1 0 00000604 00a0f009 00000604 800 2 4 0 0 1 1e 0 00001000 00000000 1 00001000
d 1 0 00000700 00221820 00000700 800 1 1 0 0 1 03 0 00000005 00000007 0 00000000
d 1 1 00000800 00221820 00000700 800 1 1 0 0 1 03 0 00000005 00000007 0 00000000
d 1 0 00000800 00221820 00000800 800 1 1 0 0 1 03 0 00000005 00000007 0 00000000
